// ==== project.f ====
verilog/peak_search_pkg.sv
verilog/mag_squared.sv
verilog/peak_detector.sv
verilog/peak_logger.sv
verilog/peak_search_top.sv
tests/tb_clock.sv
tests/peak_search_properties.sv
tests/peak_search_tb.sv

// ==== tests/peak_search_properties.sv ====
module peak_search_properties (
    input logic clk_i,
    input logic reset_ni,
    input logic sample_valid_i,
    input logic best_clear_i,
    input logic peak_strobe_i,
    input logic best_valid_i
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;  // Assertion failures so far.

    // Fixed three-cycle latency from input strobe to peak strobe.
    strobe_after_sample: assert property (
        @(posedge clk_i) disable iff (!reset_ni)
        peak_strobe_i |-> $past(sample_valid_i, 3)
    ) else begin
        $error("peak_strobe_o without sample_valid_i three cycles earlier");
        fail_count++;
    end

    // One reset edge clears the pulse and flag outputs.
    outputs_low_in_reset: assert property (
        @(posedge clk_i)
        !reset_ni ##1 !reset_ni |-> !peak_strobe_i && !best_valid_i
    ) else begin
        $error("peak_strobe_o or best_valid_o high during reset");
        fail_count++;
    end

    best_falls_on_clear: assert property (
        @(posedge clk_i) disable iff (!reset_ni)
        $fell(best_valid_i) |-> $past(best_clear_i)
    ) else begin
        $error("best_valid_o fell without best_clear_i");
        fail_count++;
    end

endmodule

bind peak_search_top peak_search_properties u_properties (
    .clk_i          (clk_i),
    .reset_ni       (reset_ni),
    .sample_valid_i (sample_valid_i),
    .best_clear_i   (best_clear_i),
    .peak_strobe_i  (peak_strobe_o),
    .best_valid_i   (best_valid_o)
);

// ==== tests/peak_search_tb.sv ====
module peak_search_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import peak_search_pkg::*;

    localparam int WINDOW_LEN  = 8;
    localparam int LOG_LEN     = $clog2(WINDOW_LEN);
    localparam int DRAIN_LIMIT = 64;  // Cycles allowed for the pipeline to empty.

    logic               clk;
    logic               reset_n;
    logic               sample_valid;
    iq_sample_t         sample;
    mag_t               noise_limit;
    logic [SHIFT_W-1:0] detection_shift;
    logic               best_clear;
    logic               peak_strobe;
    peak_event_t        peak;
    logic               best_valid;
    peak_event_t        best;

    integer             seed;
    int                 idle_cycles;
    int                 peak_count;
    longint             win_mags[$];
    logic [INDEX_W-1:0] eval_index;
    peak_event_t        exp_peaks[$];
    peak_event_t        exp_best;
    logic               exp_best_valid;

    tb_clock u_clock (
        .clk_o (clk)
    );

    peak_search_top #(
        .WINDOW_LEN (WINDOW_LEN)
    ) dut (
        .clk_i             (clk),
        .reset_ni          (reset_n),
        .sample_valid_i    (sample_valid),
        .sample_i          (sample),
        .noise_limit_i     (noise_limit),
        .detection_shift_i (detection_shift),
        .best_clear_i      (best_clear),
        .peak_strobe_o     (peak_strobe),
        .peak_o            (peak),
        .best_valid_o      (best_valid),
        .best_o            (best)
    );

    task automatic stop_on_error(string what);
        $display("%s", what);
        $display("Done: errors found");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_peak(peak_event_t got, peak_event_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf(
                "error peak_o: got index %h score %h, expected index %h score %h",
                got.index, got.score, exp.index, exp.score));
        end
    endtask

    task automatic check_best(peak_event_t got, peak_event_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf(
                "error best_o: got index %h score %h, expected index %h score %h",
                got.index, got.score, exp.index, exp.score));
        end
    endtask

    task automatic check_flag(logic got, logic exp);
        if (got !== exp) begin
            stop_on_error($sformatf("error best_valid_o: got %h expected %h", got, exp));
        end
    endtask

    function automatic longint reference_level(longint sum, int shift);
        int k;
        k = LOG_LEN - shift;
        if (k > 0) begin
            return sum >> k;
        end else begin
            return sum << -k;
        end
    endfunction

    // Model of one valid sample, using the inputs as they stand now.
    task automatic model_sample(int i_val, int q_val);
        longint      m;
        longint      sum;
        longint      ref_lvl;
        peak_event_t ev;
        m = longint'(i_val) * i_val + longint'(q_val) * q_val;
        if (win_mags.size() == WINDOW_LEN) begin
            sum = 0;
            foreach (win_mags[n]) begin
                sum += win_mags[n];
            end
            ref_lvl = reference_level(sum, int'(detection_shift));
            if (m > ref_lvl && m > longint'(noise_limit)) begin
                ev.index = eval_index;
                ev.score = mag_t'(m - ref_lvl);
                exp_peaks.push_back(ev);
                peak_count++;
                if (!exp_best_valid || ev.score > exp_best.score) begin
                    exp_best       = ev;
                    exp_best_valid = 1'b1;
                end
            end
            eval_index++;
            void'(win_mags.pop_front());
        end
        win_mags.push_back(m);
    endtask

    task automatic send_sample(int i_val, int q_val);
        @(negedge clk);
        sample_valid = 1'b1;
        sample.i     = i_val[SAMPLE_W-1:0];
        sample.q     = q_val[SAMPLE_W-1:0];
        idle_cycles  = 0;
        model_sample(i_val, q_val);
    endtask

    task automatic idle_cycle();
        @(negedge clk);
        sample_valid = 1'b0;
        idle_cycles++;
    endtask

    task automatic send_zeros(int count);
        repeat (count) begin
            send_sample(0, 0);
        end
    endtask

    // Last strobe lands three cycles after the last sample.
    task automatic drain_pipeline();
        int waited;
        waited = 0;
        while ((exp_peaks.size() != 0 || idle_cycles < 4) && waited < DRAIN_LIMIT) begin
            idle_cycle();
            waited++;
        end
        if (exp_peaks.size() != 0 || idle_cycles < 4) begin
            stop_on_error($sformatf("timeout: %0d expected peaks never appeared on peak_strobe_o",
                                    exp_peaks.size()));
        end
    endtask

    task automatic finish_phase();
        drain_pipeline();
        check_flag(best_valid, exp_best_valid);
        if (exp_best_valid) begin
            check_best(best, exp_best);
        end
    endtask

    task automatic random_phase(int count);
        int i_val;
        int q_val;
        int gap;
        for (int n = 0; n < count; n++) begin
            if (($random(seed) & 15) == 0) begin
                i_val = $random(seed) % 2048;  // Burst.
                q_val = $random(seed) % 2048;
            end else begin
                i_val = $random(seed) % 32;
                q_val = $random(seed) % 32;
            end
            send_sample(i_val, q_val);
            if (($random(seed) & 3) == 0) begin
                gap = 1 + ($random(seed) & 3);
                repeat (gap) begin
                    idle_cycle();
                end
            end
        end
    endtask

    task automatic pulse_clear();
        @(negedge clk);
        best_clear = 1'b1;
        @(negedge clk);
        best_clear     = 1'b0;
        exp_best_valid = 1'b0;
    endtask

    always @(negedge clk) begin
        if (reset_n === 1'b1 && peak_strobe === 1'b1) begin
            if (exp_peaks.size() == 0) begin
                stop_on_error("peak_strobe_o pulsed when no peak was expected");
            end else begin
                check_peak(peak, exp_peaks.pop_front());
            end
        end
    end

    // Failures of the bound assertions end the run as well.
    always @(negedge clk) begin
        if (dut.u_properties.fail_count != 0) begin
            stop_on_error("a concurrent assertion on the DUT outputs failed");
        end
    end

    initial begin
        seed            = 32'h5170;
        idle_cycles     = 0;
        peak_count      = 0;
        eval_index      = '0;
        exp_best        = '0;
        exp_best_valid  = 1'b0;
        reset_n         = 1'b0;
        sample_valid    = 1'b0;
        sample          = '0;
        noise_limit     = '0;
        detection_shift = '0;
        best_clear      = 1'b0;

        repeat (8) @(negedge clk);
        reset_n = 1'b1;
        check_flag(best_valid, 1'b0);

        // Warm-up with rising samples, each above the partial average.
        for (int n = 0; n < WINDOW_LEN; n++) begin
            send_sample(200 * (n + 1), 0);
        end
        finish_phase();
        send_sample(2040, 0);  // First evaluated sample, index 0.
        finish_phase();

        detection_shift = SHIFT_W'(LOG_LEN);  // k of 0.
        noise_limit     = 24'd500;
        random_phase(200);
        finish_phase();

        detection_shift = 3'd1;  // Reference is a right shift.
        random_phase(150);
        finish_phase();

        detection_shift = 3'd6;  // Reference is a left shift.
        random_phase(150);
        finish_phase();

        noise_limit = 24'd9_000_000;  // Above any burst.
        random_phase(80);
        finish_phase();

        noise_limit     = '0;
        detection_shift = SHIFT_W'(LOG_LEN);
        pulse_clear();
        check_flag(best_valid, 1'b0);

        // Small peak after a clear becomes the best.
        send_zeros(WINDOW_LEN);
        send_sample(100, 0);
        finish_phase();

        // Equal scores keep the earlier index.
        send_zeros(WINDOW_LEN);
        send_sample(1000, 0);
        send_zeros(WINDOW_LEN);
        send_sample(600, -800);
        finish_phase();

        random_phase(100);
        finish_phase();

        $display("%0d peaks checked, %0d samples evaluated", peak_count, eval_index);
        if (dut.u_properties.fail_count == 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            $display("Done: errors found");
            $fatal(1, "simulation ended with assertion failures");
        end
    end

endmodule

// ==== tests/tb_clock.sv ====
module tb_clock (
    output logic clk_o
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam realtime HALF_PERIOD = 2ns;  // 4 ns period.

    initial begin
        clk_o = 1'b0;
    end

    always begin
        #HALF_PERIOD;
        clk_o = ~clk_o;
    end

endmodule

// ==== verilog/mag_squared.sv ====
module mag_squared (
    input  logic                        clk_i,
    input  logic                        reset_ni,
    input  logic                        sample_valid_i,
    input  peak_search_pkg::iq_sample_t sample_i,
    output logic                        mag_valid_o,
    output peak_search_pkg::mag_t       mag_o
);
    import peak_search_pkg::*;

    logic signed [2*SAMPLE_W-1:0] i_sq;
    logic signed [2*SAMPLE_W-1:0] q_sq;
    mag_t                         sum_sq;

    // Full 12x12 signed products are exact.
    assign i_sq = sample_i.i * sample_i.i;
    assign q_sq = sample_i.q * sample_i.q;

    // Both squares are non-negative and their sum stays below 2**MAG_W.
    assign sum_sq = mag_t'(i_sq) + mag_t'(q_sq);

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            mag_valid_o <= 1'b0;
        end else begin
            mag_valid_o <= sample_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (sample_valid_i) begin
            mag_o <= sum_sq;  // Held between samples.
        end
    end

endmodule

// ==== verilog/peak_detector.sv ====
module peak_detector #(
    parameter int WINDOW_LEN = 8
) (
    input  logic                                clk_i,
    input  logic                                reset_ni,
    input  logic                                mag_valid_i,
    input  peak_search_pkg::mag_t               mag_i,
    input  peak_search_pkg::mag_t               noise_limit_i,
    input  logic [peak_search_pkg::SHIFT_W-1:0] detection_shift_i,
    output peak_search_pkg::det_result_t        det_o
);
    import peak_search_pkg::*;

    localparam int LOG_LEN = $clog2(WINDOW_LEN);
    localparam int SUM_W   = MAG_W + LOG_LEN;
    localparam int REF_W   = SUM_W + REF_GUARD_W;
    localparam int CNT_W   = LOG_LEN + 1;
    localparam int K_W     = SHIFT_W + 2;  // Signed, holds -7 to 6.

    localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(WINDOW_LEN);

    if (WINDOW_LEN < 2 || WINDOW_LEN > 64 ||
        (WINDOW_LEN & (WINDOW_LEN - 1)) != 0) begin : g_len_check
        $error("peak_detector: WINDOW_LEN must be a power of two from 2 to 64");
    end

    mag_t                  win_q [WINDOW_LEN];
    logic [SUM_W-1:0]      sum_q;
    logic [CNT_W-1:0]      warm_cnt_q;
    logic                  warm_full;
    logic signed [K_W-1:0] k_shift;
    logic [K_W-1:0]        shift_amt;
    logic [REF_W-1:0]      sum_ext;
    logic [REF_W-1:0]      ref_level;
    logic                  hit;
    logic                  evaluated_q;
    logic                  detected_q;
    mag_t                  score_q;

    // Window holds WINDOW_LEN earlier magnitudes.
    assign warm_full = (warm_cnt_q == CNT_FULL);

    assign k_shift   = K_W'(LOG_LEN) - K_W'(detection_shift_i);
    assign shift_amt = (k_shift > 0) ? k_shift : -k_shift;
    assign sum_ext   = REF_W'(sum_q);

    // Positive k divides the sum, otherwise it is scaled up.
    always_comb begin
        if (k_shift > 0) begin
            ref_level = sum_ext >> shift_amt;
        end else begin
            ref_level = sum_ext << shift_amt;
        end
    end

    assign hit = (REF_W'(mag_i) > ref_level) && (mag_i > noise_limit_i);

    // Newest at 0, oldest at the far end.
    always_ff @(posedge clk_i) begin
        if (mag_valid_i) begin
            win_q[0] <= mag_i;
            for (int n = 1; n < WINDOW_LEN; n++) begin
                win_q[n] <= win_q[n-1];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            sum_q       <= '0;
            warm_cnt_q  <= '0;
            evaluated_q <= 1'b0;
        end else begin
            evaluated_q <= mag_valid_i && warm_full;
            if (mag_valid_i) begin
                if (warm_full) begin
                    // Oldest entry leaves as the new one enters.
                    sum_q <= sum_q + SUM_W'(mag_i) - SUM_W'(win_q[WINDOW_LEN-1]);
                end else begin
                    sum_q      <= sum_q + SUM_W'(mag_i);
                    warm_cnt_q <= warm_cnt_q + 1'b1;
                end
            end
        end
    end

    // Detection implies mag_i > ref_level, so the difference fits MAG_W.
    always_ff @(posedge clk_i) begin
        if (mag_valid_i) begin
            detected_q <= warm_full && hit;
            if (warm_full && hit) begin
                score_q <= mag_i - ref_level[MAG_W-1:0];
            end else begin
                score_q <= '0;
            end
        end
    end

    assign det_o = '{
        evaluated: evaluated_q,
        detected:  detected_q,
        score:     score_q
    };

endmodule

// ==== verilog/peak_logger.sv ====
module peak_logger (
    input  logic                         clk_i,
    input  logic                         reset_ni,
    input  peak_search_pkg::det_result_t det_i,
    input  logic                         best_clear_i,
    output logic                         peak_strobe_o,
    output peak_search_pkg::peak_event_t peak_o,
    output logic                         best_valid_o,
    output peak_search_pkg::peak_event_t best_o
);
    import peak_search_pkg::*;

    logic [INDEX_W-1:0] index_q;
    logic               new_peak;
    logic               take_best;
    peak_event_t        cur_event;

    assign new_peak  = det_i.evaluated && det_i.detected;
    assign cur_event = '{index: index_q, score: det_i.score};

    // Strictly greater, so ties keep the earlier peak.
    assign take_best = new_peak &&
                       (!best_valid_o || best_clear_i || (det_i.score > best_o.score));

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            index_q       <= '0;
            peak_strobe_o <= 1'b0;
            best_valid_o  <= 1'b0;
        end else begin
            peak_strobe_o <= new_peak;
            if (det_i.evaluated) begin
                index_q <= index_q + 1'b1;  // Wraps.
            end
            if (take_best) begin
                best_valid_o <= 1'b1;
            end else if (best_clear_i) begin
                best_valid_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (new_peak) begin
            peak_o <= cur_event;
        end
        if (take_best) begin
            best_o <= cur_event;
        end
    end

endmodule

// ==== verilog/peak_search_pkg.sv ====
package peak_search_pkg;

    localparam int SAMPLE_W    = 12;  // Signed I and Q width.
    localparam int MAG_W       = 24;  // Magnitude and score width.
    localparam int INDEX_W     = 16;  // Wrapping peak index.

    // Detection shift runs 0 to 7.
    localparam int SHIFT_W     = 3;

    localparam int REF_GUARD_W = 8;   // Headroom for the left-shifted reference.

    typedef logic [MAG_W-1:0] mag_t;

    typedef struct packed {
        logic signed [SAMPLE_W-1:0] i;
        logic signed [SAMPLE_W-1:0] q;
    } iq_sample_t;

    // Valid only while evaluated is high.
    typedef struct packed {
        logic evaluated;
        logic detected;
        mag_t score;
    } det_result_t;

    typedef struct packed {
        logic [INDEX_W-1:0] index;
        mag_t               score;
    } peak_event_t;

endpackage

// ==== verilog/peak_search_top.sv ====
module peak_search_top #(
    parameter int WINDOW_LEN = 8
) (
    input  logic                                clk_i,
    input  logic                                reset_ni,
    input  logic                                sample_valid_i,
    input  peak_search_pkg::iq_sample_t         sample_i,
    input  peak_search_pkg::mag_t               noise_limit_i,
    input  logic [peak_search_pkg::SHIFT_W-1:0] detection_shift_i,
    input  logic                                best_clear_i,
    output logic                                peak_strobe_o,
    output peak_search_pkg::peak_event_t        peak_o,
    output logic                                best_valid_o,
    output peak_search_pkg::peak_event_t        best_o
);
    import peak_search_pkg::*;

    logic        mag_valid;
    mag_t        mag;
    det_result_t det;

    mag_squared u_mag_squared (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .sample_valid_i (sample_valid_i),
        .sample_i       (sample_i),
        .mag_valid_o    (mag_valid),
        .mag_o          (mag)
    );

    peak_detector #(
        .WINDOW_LEN (WINDOW_LEN)
    ) u_peak_detector (
        .clk_i             (clk_i),
        .reset_ni          (reset_ni),
        .mag_valid_i       (mag_valid),
        .mag_i             (mag),
        .noise_limit_i     (noise_limit_i),
        .detection_shift_i (detection_shift_i),
        .det_o             (det)
    );

    peak_logger u_peak_logger (
        .clk_i         (clk_i),
        .reset_ni      (reset_ni),
        .det_i         (det),
        .best_clear_i  (best_clear_i),
        .peak_strobe_o (peak_strobe_o),
        .peak_o        (peak_o),
        .best_valid_o  (best_valid_o),
        .best_o        (best_o)
    );

endmodule
